// ==== hw/mailbox_cfg.svh ====
// Sizes and register map of the host mailbox
// The FIFO depth must stay 2**MBX_AW, and the offsets assume a 4-bit byte address
`ifndef MAILBOX_CFG_SVH
`define MAILBOX_CFG_SVH

`define MBX_AW     5       // FIFO pointer width
`define MBX_DW     32      // Message word width
`define MBX_DEPTH  32      // Entries, equals 2**MBX_AW
`define AXIL_AW    4       // Byte address width on the bus

`define REG_PUSH   4'h0    // Write only, pushes one word
`define REG_POP    4'h4    // Read only, pops the head word
`define REG_STATUS 4'h8    // Read only, flags and level
`define REG_IRQ_EN 4'hC    // Read and write, bit 0

`endif

// ==== hw/mailbox_pkg.sv ====
// Storage types of the mailbox FIFO
// Widths follow the cfg header, and the level needs one bit more than a pointer
`default_nettype none

`include "mailbox_cfg.svh"

package mailbox_pkg;

   // One message as the host sees it
   typedef logic [`MBX_DW-1:0] mbx_data_t;

   // Read and write pointers wrap naturally at MBX_DEPTH
   typedef logic [`MBX_AW-1:0] mbx_addr_t;

   // Stored words, 0 to MBX_DEPTH
   typedef logic [`MBX_AW:0] mbx_level_t;

endpackage

`default_nettype wire

// ==== hw/axil_pkg.sv ====
// AXI4-Lite bus types for the mailbox slave
// Only OKAY and SLVERR are ever returned
`default_nettype none

`include "mailbox_cfg.svh"

package axil_pkg;

   typedef logic [`AXIL_AW-1:0] axil_addr_t;   // Byte address

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_t;

   typedef enum logic {
      W_IDLE,                                 // Waiting for AW and W together
      W_RESP                                  // B channel held until bready
   } wr_state_t;

   typedef enum logic {
      R_IDLE,                                 // Waiting for AR
      R_DATA                                  // R channel held until rready
   } rd_state_t;

endpackage

`default_nettype wire

// ==== hw/memory_dp.sv ====
// Distributed dual-port memory, write on the clock edge, read without a clock
// No reset on the contents, words are undefined until written
`default_nettype none

`include "mailbox_cfg.svh"

module memory_dp
(
   input  wire                   clk,
   input  wire logic             wr_en,
   input  mailbox_pkg::mbx_addr_t wr_addr,
   input  mailbox_pkg::mbx_data_t wr_data,
   input  mailbox_pkg::mbx_addr_t rd_addr,
   output mailbox_pkg::mbx_data_t rd_data
);

   mailbox_pkg::mbx_data_t mem [`MBX_DEPTH];   // Maps to LUT RAM

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;             // Single write port
      end
   end

   // Head word is visible in the same cycle
   assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// ==== hw/fifo_sync.sv ====
// 32-deep synchronous FIFO over distributed memory, flags held in registers
// No overflow or underflow check, the driver must not push when full or pop when empty
`default_nettype none

`include "mailbox_cfg.svh"

module fifo_sync
(
   input  wire                      clk,
   input  wire                      reset,
   input  wire logic                wr_en,
   input  wire logic                rd_en,
   input  mailbox_pkg::mbx_data_t    wr_data,
   output mailbox_pkg::mbx_data_t    rd_data,
   output logic                     rd_empty,
   output logic                     wr_full,
   output mailbox_pkg::mbx_level_t   level
);

   mailbox_pkg::mbx_addr_t wr_addr;           // Next slot to write
   mailbox_pkg::mbx_addr_t rd_addr;           // Current head

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_addr  <= '0;
         rd_addr  <= '0;
         level    <= '0;
         rd_empty <= 1'b1;
         wr_full  <= 1'b0;
      end
      else if (wr_en && rd_en)
      begin
         wr_addr <= wr_addr + 1'b1;           // Level and flags unchanged
         rd_addr <= rd_addr + 1'b1;
      end
      else if (wr_en)
      begin
         wr_addr  <= wr_addr + 1'b1;
         level    <= level + 1'b1;
         rd_empty <= 1'b0;
         if (level == mailbox_pkg::mbx_level_t'(`MBX_DEPTH - 1))
            wr_full <= 1'b1;                  // Last free slot taken
      end
      else if (rd_en)
      begin
         rd_addr <= rd_addr + 1'b1;
         level   <= level - 1'b1;
         wr_full <= 1'b0;
         if (level == mailbox_pkg::mbx_level_t'(1))
            rd_empty <= 1'b1;                 // Last word leaving
      end
   end

   memory_dp mem
   (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// ==== hw/mailbox_regs.sv ====
// AXI4-Lite register block of the mailbox, one outstanding write and one read
// Byte strobes are ignored and every write is a full word
`default_nettype none

`include "mailbox_cfg.svh"

module mailbox_regs
(
   input  wire                      clk,
   input  wire                      reset,
   input  axil_pkg::axil_addr_t      awaddr,
   input  wire logic                awvalid,
   output logic                     awready,
   input  mailbox_pkg::mbx_data_t    wdata,
   input  wire logic [`MBX_DW/8-1:0] wstrb,
   input  wire logic                wvalid,
   output logic                     wready,
   output axil_pkg::axil_resp_t      bresp,
   output logic                     bvalid,
   input  wire logic                bready,
   input  axil_pkg::axil_addr_t      araddr,
   input  wire logic                arvalid,
   output logic                     arready,
   output mailbox_pkg::mbx_data_t    rdata,
   output axil_pkg::axil_resp_t      rresp,
   output logic                     rvalid,
   input  wire logic                rready,
   output logic                     irq,
   output logic                     fifo_wr_en,
   output logic                     fifo_rd_en,
   output mailbox_pkg::mbx_data_t    fifo_wr_data,
   input  mailbox_pkg::mbx_data_t    fifo_rd_data,
   input  wire logic                fifo_empty,
   input  wire logic                fifo_full,
   input  mailbox_pkg::mbx_level_t   fifo_level
);

   axil_pkg::wr_state_t    wr_state;
   axil_pkg::rd_state_t    rd_state;
   axil_pkg::axil_addr_t   aw_word;           // Write offset, low bits cleared
   axil_pkg::axil_addr_t   ar_word;           // Read offset, low bits cleared
   axil_pkg::axil_resp_t   wr_resp;           // Response of the write being accepted
   axil_pkg::axil_resp_t   rd_resp;           // Response of the read being accepted
   mailbox_pkg::mbx_data_t rd_word;           // Data of the read being accepted
   mailbox_pkg::mbx_data_t status_word;
   logic                   wr_accept;
   logic                   rd_accept;
   logic                   irq_en;

   assign aw_word = {awaddr[`AXIL_AW-1:2], 2'b00};
   assign ar_word = {araddr[`AXIL_AW-1:2], 2'b00};

   // AW and W only taken together, so both readies are one signal
   assign wr_accept = (wr_state == axil_pkg::W_IDLE) && awvalid && wvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;
   assign bvalid    = (wr_state == axil_pkg::W_RESP);

   assign rd_accept = (rd_state == axil_pkg::R_IDLE) && arvalid;
   assign arready   = rd_accept;
   assign rvalid    = (rd_state == axil_pkg::R_DATA);

   assign fifo_wr_data = wdata;               // wstrb not applied

   always_comb
   begin
      status_word = '0;
      status_word[0] = fifo_empty;
      status_word[1] = fifo_full;
      status_word[8 +: `MBX_AW+1] = fifo_level; // Level in bits 13:8
   end

   // Write decode, push only when there is room
   always_comb
   begin
      fifo_wr_en = 1'b0;
      wr_resp    = axil_pkg::SLVERR;
      case (aw_word)
         `REG_PUSH:
         begin
            if (!fifo_full)
            begin
               wr_resp    = axil_pkg::OKAY;
               fifo_wr_en = wr_accept;
            end
         end
         `REG_IRQ_EN: wr_resp = axil_pkg::OKAY;
         default:     wr_resp = axil_pkg::SLVERR; // POP and STATUS are read only
      endcase
   end

   // Read decode, pop only when a word is there
   always_comb
   begin
      fifo_rd_en = 1'b0;
      rd_resp    = axil_pkg::SLVERR;
      rd_word    = '0;
      case (ar_word)
         `REG_POP:
         begin
            if (!fifo_empty)
            begin
               rd_resp    = axil_pkg::OKAY;
               rd_word    = fifo_rd_data;     // Head word before the pop
               fifo_rd_en = rd_accept;
            end
         end
         `REG_STATUS:
         begin
            rd_resp = axil_pkg::OKAY;
            rd_word = status_word;            // State before this edge
         end
         `REG_IRQ_EN:
         begin
            rd_resp    = axil_pkg::OKAY;
            rd_word[0] = irq_en;
         end
         default: rd_resp = axil_pkg::SLVERR; // PUSH is write only
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_state <= axil_pkg::W_IDLE;
         irq_en   <= 1'b0;
      end
      else if (wr_state == axil_pkg::W_IDLE)
      begin
         if (wr_accept)
         begin
            wr_state <= axil_pkg::W_RESP;
            if (aw_word == `REG_IRQ_EN)
               irq_en <= wdata[0];
         end
      end
      else if (bready)
      begin
         wr_state <= axil_pkg::W_IDLE;        // Response taken
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         rd_state <= axil_pkg::R_IDLE;
      else if (rd_state == axil_pkg::R_IDLE)
      begin
         if (rd_accept)
            rd_state <= axil_pkg::R_DATA;
      end
      else if (rready)
         rd_state <= axil_pkg::R_IDLE;
   end

   // Response payload captured at acceptance
   always_ff @(posedge clk)
   begin
      if (wr_accept)
         bresp <= wr_resp;
      if (rd_accept)
      begin
         rresp <= rd_resp;
         rdata <= rd_word;
      end
   end

   // Level interrupt, one cycle behind flag or enable
   always_ff @(posedge clk)
   begin
      if (reset)
         irq <= 1'b0;
      else
         irq <= irq_en && !fifo_empty;
   end

endmodule

`default_nettype wire

// ==== hw/mailbox_top.sv ====
// Host mailbox, AXI4-Lite register block in front of a 32-deep FIFO
// Single clock domain, one outstanding write and one outstanding read
`default_nettype none

`include "mailbox_cfg.svh"

module mailbox_top
(
   input  wire                      clk,
   input  wire                      reset,
   input  axil_pkg::axil_addr_t      awaddr,
   input  wire logic                awvalid,
   output logic                     awready,
   input  mailbox_pkg::mbx_data_t    wdata,
   input  wire logic [`MBX_DW/8-1:0] wstrb,
   input  wire logic                wvalid,
   output logic                     wready,
   output axil_pkg::axil_resp_t      bresp,
   output logic                     bvalid,
   input  wire logic                bready,
   input  axil_pkg::axil_addr_t      araddr,
   input  wire logic                arvalid,
   output logic                     arready,
   output mailbox_pkg::mbx_data_t    rdata,
   output axil_pkg::axil_resp_t      rresp,
   output logic                     rvalid,
   input  wire logic                rready,
   output logic                     irq
);

   logic                    fifo_wr_en;
   logic                    fifo_rd_en;
   mailbox_pkg::mbx_data_t  fifo_wr_data;
   mailbox_pkg::mbx_data_t  fifo_rd_data;     // Head word, asynchronous
   logic                    fifo_empty;
   logic                    fifo_full;
   mailbox_pkg::mbx_level_t fifo_level;

   mailbox_regs regs
   (
      .clk          (clk),
      .reset        (reset),
      .awaddr       (awaddr),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wvalid       (wvalid),
      .wready       (wready),
      .bresp        (bresp),
      .bvalid       (bvalid),
      .bready       (bready),
      .araddr       (araddr),
      .arvalid      (arvalid),
      .arready      (arready),
      .rdata        (rdata),
      .rresp        (rresp),
      .rvalid       (rvalid),
      .rready       (rready),
      .irq          (irq),
      .fifo_wr_en   (fifo_wr_en),
      .fifo_rd_en   (fifo_rd_en),
      .fifo_wr_data (fifo_wr_data),
      .fifo_rd_data (fifo_rd_data),
      .fifo_empty   (fifo_empty),
      .fifo_full    (fifo_full),
      .fifo_level   (fifo_level)
   );

   fifo_sync fifo
   (
      .clk      (clk),
      .reset    (reset),
      .wr_en    (fifo_wr_en),
      .rd_en    (fifo_rd_en),
      .wr_data  (fifo_wr_data),
      .rd_data  (fifo_rd_data),
      .rd_empty (fifo_empty),
      .wr_full  (fifo_full),
      .level    (fifo_level)
   );

endmodule

`default_nettype wire

// ==== test/mailbox_assert.sv ====
// Handshake and FIFO guard properties, bound into every mailbox_regs instance
// Checks are off while reset is high
`default_nettype none

module mailbox_assert
(
   input wire logic clk,
   input wire logic reset,
   input wire logic bvalid,
   input wire logic bready,
   input wire logic rvalid,
   input wire logic rready,
   input wire logic fifo_wr_en,
   input wire logic fifo_rd_en,
   input wire logic fifo_full,
   input wire logic fifo_empty
);

   bvalid_held: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   rvalid_held: assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   no_push_full: assert property (@(posedge clk) disable iff (reset)
      fifo_wr_en |-> !fifo_full)
      else $error("FIFO write enable while full");

   no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      fifo_rd_en |-> !fifo_empty)
      else $error("FIFO read enable while empty");

endmodule

bind mailbox_regs mailbox_assert checks
(
   .clk (clk), .reset (reset),
   .bvalid (bvalid), .bready (bready),
   .rvalid (rvalid), .rready (rready),
   .fifo_wr_en (fifo_wr_en), .fifo_rd_en (fifo_rd_en),
   .fifo_full (fifo_full), .fifo_empty (fifo_empty)
);

`default_nettype wire

// ==== test/mailbox_tb.sv ====
// Random AXI4-Lite traffic against a queue model of the mailbox, stops at the first mismatch
// Inputs change on the falling edge, outputs are sampled on the rising edge before it updates
`default_nettype none

`include "mailbox_cfg.svh"

module mailbox_tb;

   localparam int NUM_RANDOM = 120;             // Mixed ops, each followed by a STATUS read
   localparam int MAX_CYCLES = 400 * 8 + 800;   // ~400 transactions plus reset and idle gaps

   logic                    clk;
   logic                    reset;
   axil_pkg::axil_addr_t    awaddr;
   logic                    awvalid;
   logic                    awready;
   mailbox_pkg::mbx_data_t  wdata;
   logic [`MBX_DW/8-1:0]    wstrb;
   logic                    wvalid;
   logic                    wready;
   axil_pkg::axil_resp_t    bresp;
   logic                    bvalid;
   logic                    bready;
   axil_pkg::axil_addr_t    araddr;
   logic                    arvalid;
   logic                    arready;
   mailbox_pkg::mbx_data_t  rdata;
   axil_pkg::axil_resp_t    rresp;
   logic                    rvalid;
   logic                    rready;
   logic                    irq;

   mailbox_pkg::mbx_data_t  model [$];          // Expected FIFO content
   logic                    irq_en_model;
   int                      cycles;

   mailbox_top DUT
   (
      .clk (clk), .reset (reset),
      .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
      .irq (irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;                   // Period 20
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Run timed out, a handshake never completed");
         $display("Result: FAILED");
         $fatal(1);
      end
   end

   task automatic check_data(input string name, input mailbox_pkg::mbx_data_t got,
                             input mailbox_pkg::mbx_data_t exp);
      if (got !== exp)
      begin
         $display("Fail %s got %h expected %h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_resp(input string name, input axil_pkg::axil_resp_t got,
                             input axil_pkg::axil_resp_t exp);
      if (got !== exp)
      begin
         $display("Fail %s got %h expected %h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_level(input string name, input mailbox_pkg::mbx_level_t got,
                              input mailbox_pkg::mbx_level_t exp);
      if (got !== exp)
      begin
         $display("Fail %s got %h expected %h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Fail %s got %h expected %h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic axil_write(input axil_pkg::axil_addr_t addr, input mailbox_pkg::mbx_data_t data,
                             output axil_pkg::axil_resp_t resp);
      int stall;
      stall = $urandom_range(3);                // bready back-pressure
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      wstrb   = $urandom;                       // Ignored by the DUT
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(posedge clk);
      while (!(awready && wready))
         @(posedge clk);
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      repeat (stall) @(negedge clk);
      bready = 1'b1;
      @(posedge clk);
      while (!bvalid)
         @(posedge clk);
      resp = bresp;
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axil_read(input axil_pkg::axil_addr_t addr, output mailbox_pkg::mbx_data_t data,
                            output axil_pkg::axil_resp_t resp);
      int stall;
      stall = $urandom_range(3);                // rready back-pressure
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      @(posedge clk);
      while (!arready)
         @(posedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      repeat (stall) @(negedge clk);
      rready = 1'b1;
      @(posedge clk);
      while (!rvalid)
         @(posedge clk);
      data = rdata;
      resp = rresp;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic push_word(input mailbox_pkg::mbx_data_t data);
      axil_pkg::axil_resp_t resp;
      axil_write(`REG_PUSH, data, resp);
      if (model.size() < `MBX_DEPTH)
      begin
         check_resp("bresp", resp, axil_pkg::OKAY);
         model.push_back(data);
      end
      else
         check_resp("bresp", resp, axil_pkg::SLVERR);   // Full, word dropped
   endtask

   task automatic pop_word;
      mailbox_pkg::mbx_data_t data;
      axil_pkg::axil_resp_t   resp;
      axil_read(`REG_POP, data, resp);
      if (model.size() == 0)
      begin
         check_resp("rresp", resp, axil_pkg::SLVERR);
         check_data("rdata", data, '0);
      end
      else
      begin
         check_resp("rresp", resp, axil_pkg::OKAY);
         check_data("rdata", data, model.pop_front());  // Arrival order
      end
   endtask

   task automatic write_irq_en(input logic en);
      axil_pkg::axil_resp_t resp;
      axil_write(`REG_IRQ_EN, {31'b0, en}, resp);
      check_resp("bresp", resp, axil_pkg::OKAY);
      irq_en_model = en;
   endtask

   task automatic read_irq_en;
      mailbox_pkg::mbx_data_t data;
      axil_pkg::axil_resp_t   resp;
      axil_read(`REG_IRQ_EN, data, resp);
      check_resp("rresp", resp, axil_pkg::OKAY);
      check_data("rdata", data, {31'b0, irq_en_model});
   endtask

   // 0 writes POP, 1 writes STATUS, 2 reads PUSH
   task automatic access_unused(input int kind);
      mailbox_pkg::mbx_data_t data;
      axil_pkg::axil_resp_t   resp;
      if (kind == 2)
      begin
         axil_read(`REG_PUSH, data, resp);
         check_resp("rresp", resp, axil_pkg::SLVERR);
         check_data("rdata", data, '0);
      end
      else
      begin
         axil_write(kind == 0 ? `REG_POP : `REG_STATUS, $urandom, resp);
         check_resp("bresp", resp, axil_pkg::SLVERR);
      end
   endtask

   // STATUS fields against the model, then irq after an idle gap
   task automatic check_status;
      mailbox_pkg::mbx_data_t data;
      axil_pkg::axil_resp_t   resp;
      axil_read(`REG_STATUS, data, resp);
      check_resp("rresp", resp, axil_pkg::OKAY);
      check_bit("status.empty", data[0], model.size() == 0);
      check_bit("status.full", data[1], model.size() == `MBX_DEPTH);
      check_level("status.level", mailbox_pkg::mbx_level_t'(data[13:8]),
                  mailbox_pkg::mbx_level_t'(model.size()));
      check_data("status.unused", data & ~32'h0000_3f03, '0);
      repeat (2) @(posedge clk);
      check_bit("irq", irq, irq_en_model && (model.size() != 0));
   endtask

   initial
   begin
      int seed;
      int pick;
      seed         = $urandom(32'hbdc2);        // Single seed for the run
      cycles       = 0;
      irq_en_model = 1'b0;
      reset        = 1'b1;
      awaddr       = '0;
      awvalid      = 1'b0;
      wdata        = '0;
      wstrb        = '0;
      wvalid       = 1'b0;
      bready       = 1'b0;
      araddr       = '0;
      arvalid      = 1'b0;
      rready       = 1'b0;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      check_bit("awready", awready, 1'b0);
      check_bit("arready", arready, 1'b0);
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("rvalid", rvalid, 1'b0);
      check_bit("irq", irq, 1'b0);
      check_status;
      read_irq_en;                              // Zero after reset
      pop_word;                                 // Empty pop
      check_status;
      for (int k = 0; k < 3; k++)
      begin
         access_unused(k);
         check_status;                          // State untouched
      end
      write_irq_en(1'b1);
      read_irq_en;
      repeat (`MBX_DEPTH)
      begin
         push_word($urandom);
         check_status;
      end
      push_word($urandom);                      // Overflow attempt
      check_status;
      repeat (`MBX_DEPTH)
      begin
         pop_word;
         check_status;
      end
      pop_word;                                 // Underflow attempt
      check_status;
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         pick = $urandom_range(15);
         if (pick < 7)
            push_word($urandom);
         else if (pick < 13)
            pop_word;
         else if (pick == 13)
         begin
            write_irq_en(!irq_en_model);
            read_irq_en;
         end
         else
            access_unused($urandom_range(2));
         check_status;
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/mailbox_pkg.sv
hw/axil_pkg.sv
hw/memory_dp.sv
hw/fifo_sync.sv
hw/mailbox_regs.sv
hw/mailbox_top.sv
test/mailbox_assert.sv
test/mailbox_tb.sv

// ==== Bender.yml ====
package:
  name: mailbox

export_include_dirs:
  - hw

sources:
  - files:
      - hw/mailbox_pkg.sv
      - hw/axil_pkg.sv
      - hw/memory_dp.sv
      - hw/fifo_sync.sv
      - hw/mailbox_regs.sv
      - hw/mailbox_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/mailbox_assert.sv
      - test/mailbox_tb.sv
